//--- design/dispatch_pkg.sv
package dispatch_pkg;

    typedef logic [31:0] word_t;      // data, instruction or control word.
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] excp_arg_t;  // low half of the instruction.
    typedef logic [3:0]  dmem_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [3:0]  cls_t;
    typedef logic [3:0]  subop_t;

    // instruction classes, control bits 3..0.
    localparam cls_t CLS_ALU = 4'd0;
    localparam cls_t CLS_MUL = 4'd2;
    localparam cls_t CLS_DIV = 4'd4;
    localparam cls_t CLS_MEM = 4'd5;

    // control word layout.
    localparam int CTL_CLS_LSB   = 0;
    localparam int CTL_SUBOP_LSB = 4;
    localparam int CTL_USE_IMM   = 8;
    localparam int CTL_WRITES_RD = 9;
    localparam int CTL_IS_STORE  = 10;

    // alu sub-operations.
    localparam subop_t SUB_ADD = 4'd0;
    localparam subop_t SUB_SUB = 4'd1;
    localparam subop_t SUB_AND = 4'd2;
    localparam subop_t SUB_OR  = 4'd3;
    localparam subop_t SUB_XOR = 4'd4;

    localparam opcode_t OP_ADD  = 6'd0;
    localparam opcode_t OP_SUB  = 6'd1;
    localparam opcode_t OP_AND  = 6'd2;
    localparam opcode_t OP_OR   = 6'd3;
    localparam opcode_t OP_XOR  = 6'd4;
    localparam opcode_t OP_ADDI = 6'd5;
    localparam opcode_t OP_MUL  = 6'd6;
    localparam opcode_t OP_DIVU = 6'd7;
    localparam opcode_t OP_LD   = 6'd8;
    localparam opcode_t OP_ST   = 6'd9;  // highest legal opcode.

    function automatic cls_t ctl_cls(word_t ctl);
        return ctl[CTL_CLS_LSB +: 4];
    endfunction

    function automatic subop_t ctl_subop(word_t ctl);
        return ctl[CTL_SUBOP_LSB +: 4];
    endfunction

    // alu, mul and div may run on lane 0.
    function automatic logic is_arith(word_t ctl);
        return ctl_cls(ctl) == CLS_ALU || ctl_cls(ctl) == CLS_MUL
            || ctl_cls(ctl) == CLS_DIV;
    endfunction

endpackage

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import dispatch_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t ra0,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t ra3,
    input  logic     we0,
    input  reg_idx_t wa0,
    input  word_t    wd0,
    input  logic     we1,
    input  reg_idx_t wa1,
    input  word_t    wd1,
    output word_t    rd_data0,
    output word_t    rd_data1,
    output word_t    rd_data2,
    output word_t    rd_data3
);

    word_t regs [32];

    assign rd_data0 = (ra0 == '0) ? '0 : regs[ra0];
    assign rd_data1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd_data2 = (ra2 == '0) ? '0 : regs[ra2];
    assign rd_data3 = (ra3 == '0) ? '0 : regs[ra3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else begin
            if (we0 && wa0 != '0) regs[wa0] <= wd0;
            if (we1 && wa1 != '0) regs[wa1] <= wd1;  // lane 1 last, wins a clash.
        end
    end

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import dispatch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  word_t     inst0,
    input  word_t     inst1,
    output logic      dec_valid,
    output reg_idx_t  rd0,
    output reg_idx_t  rd1,
    output reg_idx_t  rj0,
    output reg_idx_t  rj1,
    output reg_idx_t  rk0,
    output reg_idx_t  rk1,
    output word_t     imm0,
    output word_t     imm1,
    output word_t     control0,
    output word_t     control1,
    output excp_arg_t excp_arg0,
    output excp_arg_t excp_arg1,
    output logic      ine0,
    output logic      ine1
);

    // opcode to control word, zero for unknown opcodes.
    function automatic word_t ctrl_of(opcode_t op);
        word_t  c;
        cls_t   cls;
        subop_t sub;
        logic   use_imm;
        logic   st;
        c       = '0;
        cls     = CLS_ALU;
        sub     = SUB_ADD;
        use_imm = 1'b0;
        st      = 1'b0;
        case (op)
            OP_ADD:  sub = SUB_ADD;
            OP_SUB:  sub = SUB_SUB;
            OP_AND:  sub = SUB_AND;
            OP_OR:   sub = SUB_OR;
            OP_XOR:  sub = SUB_XOR;
            OP_ADDI: use_imm = 1'b1;
            OP_MUL:  cls = CLS_MUL;
            OP_DIVU: cls = CLS_DIV;
            OP_LD: begin
                cls     = CLS_MEM;
                use_imm = 1'b1;
            end
            OP_ST: begin
                cls     = CLS_MEM;
                use_imm = 1'b1;
                st      = 1'b1;
            end
            default: return '0;
        endcase
        c[CTL_CLS_LSB +: 4]   = cls;
        c[CTL_SUBOP_LSB +: 4] = sub;
        c[CTL_USE_IMM]        = use_imm;
        c[CTL_WRITES_RD]      = !st;
        c[CTL_IS_STORE]       = st;
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            rd0       <= inst0[25:21];
            rj0       <= inst0[20:16];
            rk0       <= inst0[15:11];
            imm0      <= {{16{inst0[15]}}, inst0[15:0]};
            control0  <= ctrl_of(inst0[31:26]);
            excp_arg0 <= inst0[15:0];
            ine0      <= inst0[31:26] > OP_ST;
            rd1       <= inst1[25:21];
            rj1       <= inst1[20:16];
            rk1       <= inst1[15:11];
            imm1      <= {{16{inst1[15]}}, inst1[15:0]};
            control1  <= ctrl_of(inst1[31:26]);
            excp_arg1 <= inst1[15:0];
            ine1      <= inst1[31:26] > OP_ST;
        end
    end

endmodule

//--- design/issue_dispatcher.sv
`timescale 1ns/1ps

module issue_dispatcher
    import dispatch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      dec_valid,
    input  reg_idx_t  rd0,
    input  reg_idx_t  rd1,
    input  reg_idx_t  rj0,
    input  reg_idx_t  rj1,
    input  reg_idx_t  rk0,
    input  reg_idx_t  rk1,
    input  word_t     imm0,
    input  word_t     imm1,
    input  word_t     control0,
    input  word_t     control1,
    input  excp_arg_t excp_arg0,
    input  excp_arg_t excp_arg1,
    input  logic      ine0,
    input  logic      ine1,
    output logic      iss0_valid,
    output reg_idx_t  iss0_rd,
    output reg_idx_t  iss0_rj,
    output reg_idx_t  iss0_rk,
    output word_t     iss0_imm,
    output word_t     iss0_control,
    output excp_arg_t iss0_excp_arg,
    output logic      iss0_ine,
    output logic      iss1_valid,
    output reg_idx_t  iss1_rd,
    output reg_idx_t  iss1_rj,
    output reg_idx_t  iss1_rk,
    output word_t     iss1_imm,
    output word_t     iss1_control,
    output excp_arg_t iss1_excp_arg,
    output logic      iss1_ine
);

    logic      hold_valid;  // younger of a split pair.
    reg_idx_t  hold_rd, hold_rj, hold_rk;
    word_t     hold_imm, hold_control;
    excp_arg_t hold_excp_arg;
    logic      hold_ine;

    // raw index compare, also on fields an instruction does not use.
    wire related = rd0 == rd1 || rd0 == rk1 || rd0 == rj1 || rd1 == rk0 || rd1 == rj0;
    wire plain   = !related && is_arith(control0);
    wire swap    = !related && ctl_cls(control0) == CLS_MEM && is_arith(control1);
    wire paired  = plain || swap;
    wire hold_arith = is_arith(hold_control);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss0_valid <= 1'b0;
            iss1_valid <= 1'b0;
            hold_valid <= 1'b0;
        end else if (dec_valid) begin
            iss0_valid <= paired;
            iss1_valid <= 1'b1;      // older or swapped memory op.
            hold_valid <= !paired;
        end else if (hold_valid) begin
            iss0_valid <= hold_arith;
            iss1_valid <= !hold_arith;
            hold_valid <= 1'b0;
        end else begin
            iss0_valid <= 1'b0;
            iss1_valid <= 1'b0;
        end
    end

    // lane 1 takes the older unless the pair goes out in order.
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            iss0_rd       <= plain ? rd0 : rd1;
            iss0_rj       <= plain ? rj0 : rj1;
            iss0_rk       <= plain ? rk0 : rk1;
            iss0_imm      <= plain ? imm0 : imm1;
            iss0_control  <= plain ? control0 : control1;
            iss0_excp_arg <= plain ? excp_arg0 : excp_arg1;
            iss0_ine      <= plain ? ine0 : ine1;
            iss1_rd       <= plain ? rd1 : rd0;
            iss1_rj       <= plain ? rj1 : rj0;
            iss1_rk       <= plain ? rk1 : rk0;
            iss1_imm      <= plain ? imm1 : imm0;
            iss1_control  <= plain ? control1 : control0;
            iss1_excp_arg <= plain ? excp_arg1 : excp_arg0;
            iss1_ine      <= plain ? ine1 : ine0;
            hold_rd       <= rd1;
            hold_rj       <= rj1;
            hold_rk       <= rk1;
            hold_imm      <= imm1;
            hold_control  <= control1;
            hold_excp_arg <= excp_arg1;
            hold_ine      <= ine1;
        end else if (hold_valid) begin
            iss0_rd       <= hold_rd;
            iss0_rj       <= hold_rj;
            iss0_rk       <= hold_rk;
            iss0_imm      <= hold_imm;
            iss0_control  <= hold_control;
            iss0_excp_arg <= hold_excp_arg;
            iss0_ine      <= hold_ine;
            iss1_rd       <= hold_rd;
            iss1_rj       <= hold_rj;
            iss1_rk       <= hold_rk;
            iss1_imm      <= hold_imm;
            iss1_control  <= hold_control;
            iss1_excp_arg <= hold_excp_arg;
            iss1_ine      <= hold_ine;
        end
    end

endmodule

//--- design/exec_lanes.sv
`timescale 1ns/1ps

module exec_lanes
    import dispatch_pkg::*;
#(
    parameter int DMEM_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      iss0_valid,
    input  reg_idx_t  iss0_rd,
    input  reg_idx_t  iss0_rj,
    input  reg_idx_t  iss0_rk,
    input  word_t     iss0_imm,
    input  word_t     iss0_control,
    input  excp_arg_t iss0_excp_arg,
    input  logic      iss0_ine,
    input  logic      iss1_valid,
    input  reg_idx_t  iss1_rd,
    input  reg_idx_t  iss1_rj,
    input  reg_idx_t  iss1_rk,
    input  word_t     iss1_imm,
    input  word_t     iss1_control,
    input  excp_arg_t iss1_excp_arg,
    input  logic      iss1_ine,
    output logic      wb0_valid,
    output reg_idx_t  wb0_rd,
    output word_t     wb0_data,
    output logic      wb1_valid,
    output reg_idx_t  wb1_rd,
    output word_t     wb1_data,
    output logic      exc_valid,
    output excp_arg_t exc_arg
);

    localparam dmem_idx_t ADDR_MASK = dmem_idx_t'(DMEM_DEPTH - 1);

    word_t     dmem [DMEM_DEPTH];
    word_t     rj0_val, rk0_val, rj1_val, rk1_val;
    dmem_idx_t mem_addr;
    word_t     res0, res1;

    wire is_store = iss1_control[CTL_IS_STORE];
    wire we0      = iss0_valid && iss0_control[CTL_WRITES_RD];
    wire we1      = iss1_valid && iss1_control[CTL_WRITES_RD];
    wire store_en = iss1_valid && is_store;
    wire exc0     = iss0_valid && iss0_ine;
    wire exc1     = iss1_valid && iss1_ine;

    function automatic word_t arith(word_t ctl, word_t a, word_t b);
        case (ctl_cls(ctl))
            CLS_MUL: return a * b;                      // low half only.
            CLS_DIV: return (b == '0) ? '1 : a / b;
            default: begin
                case (ctl_subop(ctl))
                    SUB_SUB: return a - b;
                    SUB_AND: return a & b;
                    SUB_OR:  return a | b;
                    SUB_XOR: return a ^ b;
                    default: return a + b;
                endcase
            end
        endcase
    endfunction

    // port 3 carries rd for a store, its data source.
    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ra0      (iss0_rj),
        .ra1      (iss0_rk),
        .ra2      (iss1_rj),
        .ra3      (is_store ? iss1_rd : iss1_rk),
        .we0      (we0),
        .wa0      (iss0_rd),
        .wd0      (res0),
        .we1      (we1),
        .wa1      (iss1_rd),
        .wd1      (res1),
        .rd_data0 (rj0_val),
        .rd_data1 (rk0_val),
        .rd_data2 (rj1_val),
        .rd_data3 (rk1_val)
    );

    assign mem_addr = dmem_idx_t'(rj1_val + iss1_imm) & ADDR_MASK;

    assign res0 = arith(iss0_control, rj0_val,
                        iss0_control[CTL_USE_IMM] ? iss0_imm : rk0_val);
    assign res1 = (ctl_cls(iss1_control) == CLS_MEM) ? dmem[mem_addr]
                : arith(iss1_control, rj1_val,
                        iss1_control[CTL_USE_IMM] ? iss1_imm : rk1_val);

    always_ff @(posedge clk) begin
        if (store_en) dmem[mem_addr] <= rk1_val;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb0_valid <= 1'b0;
            wb1_valid <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb0_valid <= we0;
            wb1_valid <= we1;
            exc_valid <= exc0 || exc1;
        end
    end

    always_ff @(posedge clk) begin
        wb0_rd   <= iss0_rd;
        wb0_data <= res0;
        wb1_rd   <= iss1_rd;
        wb1_data <= res1;
        exc_arg  <= exc0 ? iss0_excp_arg : iss1_excp_arg;  // lane 0 holds the older.
    end

endmodule

//--- design/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core
    import dispatch_pkg::*;
#(
    parameter int DMEM_DEPTH = 16
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  word_t     inst0,      // older.
    input  word_t     inst1,
    output logic      wb0_valid,
    output reg_idx_t  wb0_rd,
    output word_t     wb0_data,
    output logic      wb1_valid,
    output reg_idx_t  wb1_rd,
    output word_t     wb1_data,
    output logic      exc_valid,
    output excp_arg_t exc_arg
);

    // decode to dispatch.
    logic      dec_valid;
    reg_idx_t  rd0, rd1, rj0, rj1, rk0, rk1;
    word_t     imm0, imm1, control0, control1;
    excp_arg_t excp_arg0, excp_arg1;
    logic      ine0, ine1;

    // dispatch to execute.
    logic      iss0_valid, iss1_valid;
    reg_idx_t  iss0_rd, iss0_rj, iss0_rk;
    reg_idx_t  iss1_rd, iss1_rj, iss1_rk;
    word_t     iss0_imm, iss0_control;
    word_t     iss1_imm, iss1_control;
    excp_arg_t iss0_excp_arg, iss1_excp_arg;
    logic      iss0_ine, iss1_ine;

    // ports match the wire names above.
    inst_decoder inst_decoder_i (.*);

    issue_dispatcher issue_dispatcher_i (.*);

    exec_lanes #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) exec_lanes_i (.*);

endmodule

//--- verif/dual_issue_props.sv
`timescale 1ns/1ps

module dual_issue_props (
    input logic        clk,
    input logic        rst_n,
    input logic        dec_valid,
    input logic        hold_valid,
    input logic        iss0_valid,
    input logic        iss1_valid,
    input logic [31:0] iss0_control,
    input logic [4:0]  iss0_rd,
    input logic [4:0]  iss1_rd
);

    wire [3:0] cls0 = iss0_control[3:0];

    // the gap between pairs lets the hold drain.
    no_decode_on_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !(dec_valid && hold_valid))
        else $error("decode arrived while the hold slot was occupied");

    lane0_arith_only: assert property (@(posedge clk) disable iff (!rst_n)
        iss0_valid |-> (cls0 == 4'd0 || cls0 == 4'd2 || cls0 == 4'd4))
        else $error("lane 0 issued class %0d", cls0);

    distinct_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (iss0_valid && iss1_valid) |-> iss0_rd != iss1_rd)
        else $error("both lanes issued with rd %0d", iss0_rd);

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(iss0_valid || iss1_valid || hold_valid))
        else $error("issue or hold valid set during reset");

endmodule

//--- verif/tb_dual_issue_core.sv
`timescale 1ns/1ps

module tb_dual_issue_core;

    localparam int NUM_PAIRS = 300;
    localparam int TIMEOUT   = 16;  // cycles allowed per pair.

    localparam logic [5:0] OPC_ADD  = 6'd0;
    localparam logic [5:0] OPC_SUB  = 6'd1;
    localparam logic [5:0] OPC_AND  = 6'd2;
    localparam logic [5:0] OPC_OR   = 6'd3;
    localparam logic [5:0] OPC_XOR  = 6'd4;
    localparam logic [5:0] OPC_ADDI = 6'd5;
    localparam logic [5:0] OPC_MUL  = 6'd6;
    localparam logic [5:0] OPC_DIVU = 6'd7;
    localparam logic [5:0] OPC_LD   = 6'd8;
    localparam logic [5:0] OPC_ST   = 6'd9;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic        wb0_valid;
    logic [4:0]  wb0_rd;
    logic [31:0] wb0_data;
    logic        wb1_valid;
    logic [4:0]  wb1_rd;
    logic [31:0] wb1_data;
    logic        exc_valid;
    logic [15:0] exc_arg;

    logic [31:0] rng;
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [16];

    // results still due. channel 2 is the exception.
    int          ev_ch [$];
    int          ev_lat [$];
    logic [4:0]  ev_rd [$];
    logic [31:0] ev_val [$];

    int checks;
    int mismatches;
    int other_errors;

    dual_issue_core #(
        .DMEM_DEPTH (16)
    ) dual_issue_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inst0     (inst0),
        .inst1     (inst1),
        .wb0_valid (wb0_valid),
        .wb0_rd    (wb0_rd),
        .wb0_data  (wb0_data),
        .wb1_valid (wb1_valid),
        .wb1_rd    (wb1_rd),
        .wb1_data  (wb1_data),
        .exc_valid (exc_valid),
        .exc_arg   (exc_arg)
    );

    bind issue_dispatcher dual_issue_props dual_issue_props_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .hold_valid   (hold_valid),
        .iss0_valid   (iss0_valid),
        .iss1_valid   (iss1_valid),
        .iss0_control (iss0_control),
        .iss0_rd      (iss0_rd),
        .iss1_rd      (iss1_rd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic is_mem_op(logic [5:0] op);
        return op == OPC_LD || op == OPC_ST;
    endfunction

    // unknown opcodes decode to a zero control word, the alu class.
    function automatic logic is_arith_op(logic [5:0] op);
        return !is_mem_op(op);
    endfunction

    function automatic logic is_illegal(logic [5:0] op);
        return op > OPC_ST;
    endfunction

    function automatic logic [31:0] make_inst(logic [5:0] op, logic [4:0] rd, logic [4:0] rj,
                                              logic [15:0] low);
        return {op, rd, rj, low};
    endfunction

    function automatic logic [4:0] pick_reg(logic [5:0] b);
        return (b[5:4] == 2'b11) ? b[4:0] : {2'b00, b[2:0]};  // mostly r0 to r7.
    endfunction

    function automatic logic [31:0] gen_inst();
        logic [31:0] r;
        logic [31:0] s;
        logic [5:0]  op;
        logic [4:0]  rk;
        r  = rand32();
        s  = rand32();
        rk = pick_reg(r[27:22]);
        if (r[3:0] < 4'd10) op = {2'b00, r[3:0]};
        else if (r[3:0] == 4'd10) op = OPC_LD;
        else if (r[3:0] == 4'd11) op = OPC_ST;
        else if (r[3:0] < 4'd14) op = OPC_ADDI;
        else op = 6'd10 + (r[9:4] % 6'd54);  // illegal range.
        if (op < OPC_ADDI || op == OPC_MUL || op == OPC_DIVU)
            return make_inst(op, pick_reg(r[15:10]), pick_reg(r[21:16]), {rk, s[10:0]});
        return make_inst(op, pick_reg(r[15:10]), pick_reg(r[21:16]), s[15:0]);
    endfunction

    task automatic expect_event(int ch, logic [4:0] rd, logic [31:0] val, int lat);
        ev_ch.push_back(ch);
        ev_lat.push_back(lat);
        ev_rd.push_back(rd);
        ev_val.push_back(val);
    endtask

    // executes one instruction on the model and records its visible result.
    task automatic model_exec(logic [31:0] inst, int lane, int lat);
        logic [5:0]  op;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [3:0]  addr;
        op   = inst[31:26];
        rd   = inst[25:21];
        imm  = {{16{inst[15]}}, inst[15:0]};
        a    = m_regs[inst[20:16]];
        b    = (op == OPC_ADDI || is_mem_op(op)) ? imm : m_regs[inst[15:11]];
        addr = 4'(a + imm);
        if (is_illegal(op)) begin
            expect_event(2, 5'd0, {16'h0, inst[15:0]}, lat);
        end else if (op == OPC_ST) begin
            m_mem[addr] = m_regs[rd];
        end else begin
            case (op)
                OPC_ADD, OPC_ADDI: res = a + b;
                OPC_SUB:  res = a - b;
                OPC_AND:  res = a & b;
                OPC_OR:   res = a | b;
                OPC_XOR:  res = a ^ b;
                OPC_MUL:  res = a * b;
                OPC_DIVU: res = (b == 32'h0) ? 32'hffff_ffff : a / b;
                default:  res = m_mem[addr];  // load.
            endcase
            if (rd != 5'd0) m_regs[rd] = res;
            expect_event(lane, rd, res, lat);
        end
    endtask

    task automatic take_event(int ch, string rd_name, string val_name, logic [4:0] rd,
                              logic [31:0] val, int lat);
        int idx;
        idx = -1;
        foreach (ev_ch[i]) begin
            if (idx < 0 && ev_ch[i] == ch) idx = i;
        end
        checks++;
        if (idx < 0) begin
            $display("unexpected output on %s %0d cycles after the strobe", val_name, lat);
            other_errors++;
        end else begin
            if (ev_lat[idx] != lat) begin
                $display("%s came %0d cycles after the strobe instead of %0d",
                         val_name, lat, ev_lat[idx]);
                other_errors++;
            end
            if (ch != 2 && ev_rd[idx] !== rd) begin
                $display("MISMATCH %s: got %h, expected %h", rd_name, rd, ev_rd[idx]);
                mismatches++;
            end
            if (ev_val[idx] !== val) begin
                $display("MISMATCH %s: got %h, expected %h", val_name, val, ev_val[idx]);
                mismatches++;
            end
            ev_ch.delete(idx);
            ev_lat.delete(idx);
            ev_rd.delete(idx);
            ev_val.delete(idx);
        end
    endtask

    // called on a falling edge. returns on the edge where the next pair may start.
    task automatic run_pair(logic [31:0] i0, logic [31:0] i1);
        logic related;
        logic plain;
        logic swap;
        int   lat;
        related = i0[25:21] == i1[25:21] || i0[25:21] == i1[15:11] || i0[25:21] == i1[20:16]
               || i1[25:21] == i0[15:11] || i1[25:21] == i0[20:16];
        plain = !related && is_arith_op(i0[31:26]);
        swap  = !related && is_mem_op(i0[31:26]) && is_arith_op(i1[31:26]);
        if (plain) begin
            model_exec(i0, 0, 2);
            model_exec(i1, 1, 2);
        end else if (swap) begin
            model_exec(i0, 1, 2);
            model_exec(i1, 0, 2);
        end else begin
            model_exec(i0, 1, 2);
            model_exec(i1, is_arith_op(i1[31:26]) ? 0 : 1, 3);
        end
        in_valid = 1'b1;
        inst0    = i0;
        inst1    = i1;
        lat      = -1;
        while ((ev_ch.size() > 0 || lat < 3) && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
            in_valid = 1'b0;
            if (wb0_valid) take_event(0, "wb0_rd", "wb0_data", wb0_rd, wb0_data, lat);
            if (wb1_valid) take_event(1, "wb1_rd", "wb1_data", wb1_rd, wb1_data, lat);
            if (exc_valid) take_event(2, "", "exc_arg", 5'd0, {16'h0, exc_arg}, lat);
        end
        if (ev_ch.size() > 0) begin
            $display("timeout: %0d expected results never appeared for %h %h",
                     ev_ch.size(), i0, i1);
            other_errors++;
            ev_ch.delete();
            ev_lat.delete();
            ev_rd.delete();
            ev_val.delete();
        end
    endtask

    initial begin
        logic [31:0] i0;
        logic [31:0] i1;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        inst0        = '0;
        inst1        = '0;
        rng          = 32'd94;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < 16; i++) m_mem[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // data memory powers up unknown. each word gets its own value first.
        for (int a = 0; a < 16; a++) begin
            run_pair(make_inst(OPC_ADDI, 5'd1, 5'd0, {4'(a), 4'hc, 4'(~a), 4'h3}),
                     make_inst(OPC_ST, 5'd1, 5'd0, 16'(a)));
        end
        for (int n = 0; n < NUM_PAIRS; n++) begin
            i0 = gen_inst();
            i1 = gen_inst();
            if (is_illegal(i0[31:26]) && is_illegal(i1[31:26])) i1[31:26] = OPC_ADD;
            run_pair(i0, i1);
        end
        $display("pairs %0d, checks %0d, mismatches %0d, other errors %0d",
                 NUM_PAIRS + 16, checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- dual_issue_core.f
design/dispatch_pkg.sv
design/reg_file.sv
design/inst_decoder.sv
design/issue_dispatcher.sv
design/exec_lanes.sv
design/dual_issue_core.sv
verif/dual_issue_props.sv
verif/tb_dual_issue_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dual_issue_core -f dual_issue_core.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi
